/* project.f */
if_pkg.sv
if_pc_mux.sv
if_prefetcher.sv
if_fetch_fifo.sv
if_id_register.sv
if_stage.sv
if_stage_assert.sv
tb_clock_gen.sv
tb_if_stage.sv

/* run.sh */
#!/bin/sh
# Build the IF stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_if_stage -o sim_if_stage \
  && ./obj_dir/sim_if_stage | tee /dev/stderr | grep -F "*** TEST PASSED ***" > /dev/null \
  && echo "Simulation result: pass" \
  || { echo "Simulation result: fail"; exit 1; }

/* tb_if_stage.sv */
`timescale 1ns/1ps

module tb_if_stage;

  import if_pkg::*;

  // Memory returns a bus error for this 16-byte window
  localparam addr_t ERR_BASE = 32'h0000_0200;
  localparam logic [31:0] DATA_KEY = 32'h5a5a_0000;

  // Rough cycle budget of each test
  localparam int LEN_BOOT  = 40;
  localparam int LEN_REDIR = 80;
  localparam int LEN_TRAP  = 40;
  localparam int LEN_BP    = 150;
  localparam int LEN_ERR   = 50;
  localparam int WATCHDOG_CYCLES = (LEN_BOOT + LEN_REDIR + LEN_TRAP + LEN_BP + LEN_ERR) * 4;

  logic clk;
  logic rst_n;

  // DUT inputs driven by the test sequence
  logic                    pc_set_i = 1'b0;
  pc_mux_e                 pc_mux_i = PC_BOOT;
  addr_t                   boot_addr_i = '0;
  addr_t                   jump_target_i = '0;
  addr_t                   branch_target_i = '0;
  addr_t                   mepc_i = '0;
  logic [MTVEC_BASE_W-1:0] mtvec_base_i = '0;
  logic [IRQ_ID_W-1:0]     irq_id_i = '0;
  logic                    halt_if_i = 1'b0;
  logic                    id_ready_i = 1'b1;

  // DUT inputs driven by the memory model
  logic                    instr_rvalid_i = 1'b0;
  instr_word_t             instr_rdata_i = '0;
  logic                    instr_err_i = 1'b0;

  // DUT outputs
  logic                    csr_mtvec_init_o;
  logic                    instr_req_o;
  addr_t                   instr_addr_o;
  logic                    if_valid_o;
  logic                    if_id_valid_o;
  instr_word_t             if_id_instr_o;
  addr_t                   if_id_pc_o;
  logic                    if_id_err_o;
  logic                    if_busy_o;
  addr_t                   pc_if_o;

  int errors = 0;
  int checks = 0;
  int stim_seed = 32'h8e4643a1;
  int mem_seed = 32'h8e4643a1;

  // Captured IF/ID contents, base marks the first entry after the last redirect
  addr_t       got_pc[$];
  instr_word_t got_instr[$];
  logic        got_err[$];
  addr_t       got_head_pc[$];
  int          base = 0;

  tb_clock_gen #(
    .PERIOD_NS    (100),
    .RESET_CYCLES (3)
  ) clock_gen_inst (
    .clk   (clk),
    .rst_n (rst_n)
  );

  if_stage #(
    .FETCH_DEPTH (FETCH_DEPTH_DEF)
  ) if_stage_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .mtvec_base_i     (mtvec_base_i),
    .irq_id_i         (irq_id_i),
    .csr_mtvec_init_o (csr_mtvec_init_o),
    .instr_req_o      (instr_req_o),
    .instr_addr_o     (instr_addr_o),
    .instr_rvalid_i   (instr_rvalid_i),
    .instr_rdata_i    (instr_rdata_i),
    .instr_err_i      (instr_err_i),
    .halt_if_i        (halt_if_i),
    .id_ready_i       (id_ready_i),
    .if_valid_o       (if_valid_o),
    .if_id_valid_o    (if_id_valid_o),
    .if_id_instr_o    (if_id_instr_o),
    .if_id_pc_o       (if_id_pc_o),
    .if_id_err_o      (if_id_err_o),
    .if_busy_o        (if_busy_o),
    .pc_if_o          (pc_if_o)
  );

  function automatic logic in_err_window(input addr_t addr);
    return (addr >= ERR_BASE) && (addr < ERR_BASE + 32'd16);
  endfunction

  ////////////////////////////////////////
  // Memory model and capture monitor
  ////////////////////////////////////////

  // In-order replies after 1 to 3 cycles
  initial begin : memory_model
    addr_t pend_addr[$];
    int    pend_due[$];
    int    cyc;
    int    lat;
    int    last_due;
    addr_t addr;
    cyc = 0;
    last_due = 0;
    forever begin
      @(posedge clk);
      cyc++;
      if (rst_n && instr_req_o) begin
        lat = 1 + int'($unsigned($random(mem_seed)) % 3);
        last_due = (cyc + lat > last_due) ? cyc + lat : last_due + 1;
        pend_addr.push_back(instr_addr_o);
        pend_due.push_back(last_due);
      end
      @(negedge clk);
      // Busy follows the fetches this model still owes
      if (rst_n) begin
        check_val("if_busy_o", 32'(if_busy_o), 32'(pend_addr.size() != 0));
      end
      if (pend_due.size() != 0 && pend_due[0] <= cyc + 1) begin
        addr = pend_addr.pop_front();
        pend_due.delete(0);
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = addr ^ DATA_KEY;
        instr_err_i    = in_err_window(addr);
      end else begin
        instr_rvalid_i = 1'b0;
        instr_rdata_i  = '0;
        instr_err_i    = 1'b0;
      end
    end
  end

  // A capture at a rising edge is read back from the register half a cycle later
  initial begin : capture_monitor
    logic  live;
    logic  cap;
    logic  rdy;
    logic  was_valid;
    addr_t head_pc;
    forever begin
      @(posedge clk);
      live      = rst_n;
      cap       = rst_n && if_valid_o && id_ready_i;
      rdy       = id_ready_i;
      was_valid = if_id_valid_o;
      head_pc   = pc_if_o;
      // Halt hides the FIFO head from ID
      if (live && halt_if_i) begin
        check_val("if_valid_o", 32'(if_valid_o), 32'd0);
      end
      @(negedge clk);
      if (cap) begin
        got_pc.push_back(if_id_pc_o);
        got_instr.push_back(if_id_instr_o);
        got_err.push_back(if_id_err_o);
        got_head_pc.push_back(head_pc);
      end
      // Valid rises on a capture and clears when ID is ready with nothing new
      if (live) begin
        check_val("if_id_valid_o", 32'(if_id_valid_o),
                  cap ? 32'd1 : (rdy ? 32'd0 : 32'(was_valid)));
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the tests did not complete", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

  ////////////////////////////////////////
  // Check helpers
  ////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // One-cycle pc_set, then the stream restarts at base
  task automatic redirect_to(input pc_mux_e sel);
    @(negedge clk);
    pc_set_i = 1'b1;
    pc_mux_i = sel;
    @(posedge clk);
    check_val("csr_mtvec_init_o", 32'(csr_mtvec_init_o), 32'(sel == PC_BOOT));
    base = got_pc.size();
    @(negedge clk);
    pc_set_i = 1'b0;
  endtask

  task automatic collect(input int n);
    int waited;
    waited = 0;
    while ((got_pc.size() - base) < n && waited < 16 * n + 40) begin
      @(negedge clk);
      waited++;
    end
    checks++;
    assert ((got_pc.size() - base) >= n) else begin
      errors++;
      $display("Timed out: %0d of %0d instructions reached decode", got_pc.size() - base, n);
    end
  endtask

  // Sequential words from start, data and error by address
  task automatic check_stream(input addr_t start, input int n);
    addr_t exp_pc;
    for (int i = 0; i < n && base + i < got_pc.size(); i++) begin
      exp_pc = start + addr_t'(4 * i);
      check_val("if_id_pc_o", got_pc[base + i], exp_pc);
      check_val("pc_if_o", got_head_pc[base + i], exp_pc);
      check_val("if_id_instr_o", got_instr[base + i], exp_pc ^ DATA_KEY);
      check_val("if_id_err_o", 32'(got_err[base + i]), 32'(in_err_window(exp_pc)));
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_boot;
    // Quiet until the first redirect
    repeat (4) begin
      @(negedge clk);
      check_val("instr_req_o", 32'(instr_req_o), 32'd0);
    end
    check_val("if_id_valid_o", 32'(if_id_valid_o), 32'd0);
    check_val("if_valid_o", 32'(if_valid_o), 32'd0);
    check_val("csr_mtvec_init_o", 32'(csr_mtvec_init_o), 32'd0);
    check_val("if_busy_o", 32'(if_busy_o), 32'd0);
    boot_addr_i = 32'h0000_0102;
    redirect_to(PC_BOOT);
    collect(8);
    check_stream(32'h0000_0100, 8);
  endtask

  task automatic test_redirects;
    jump_target_i   = 32'h0000_0403;
    branch_target_i = 32'h0000_0800;
    mepc_i          = 32'h0000_0c06;
    // Each redirect lands while the previous stream is still fetching
    redirect_to(PC_JUMP);
    collect(5);
    check_stream(32'h0000_0400, 5);
    redirect_to(PC_BRANCH);
    collect(5);
    check_stream(32'h0000_0800, 5);
    redirect_to(PC_MRET);
    collect(5);
    check_stream(32'h0000_0c04, 5);
  endtask

  task automatic test_traps;
    mtvec_base_i = 25'h000_0123;
    irq_id_i     = 5'd11;
    redirect_to(PC_TRAP_EXC);
    collect(4);
    check_stream(32'(mtvec_base_i) << 7, 4);
    redirect_to(PC_TRAP_IRQ);
    collect(4);
    check_stream((32'(mtvec_base_i) << 7) | (32'(irq_id_i) << 2), 4);
  endtask

  task automatic test_backpressure;
    int waited;
    jump_target_i = 32'h0000_1000;
    redirect_to(PC_JUMP);
    waited = 0;
    while ((got_pc.size() - base) < 40 && waited < 1000) begin
      @(negedge clk);
      id_ready_i = ($random(stim_seed) & 1) != 0;
      halt_if_i  = ($random(stim_seed) & 3) == 0;
      @(posedge clk);
      waited++;
    end
    @(negedge clk);
    id_ready_i = 1'b1;
    halt_if_i  = 1'b0;
    collect(40);
    check_stream(32'h0000_1000, 40);
  endtask

  task automatic test_bus_error;
    int n_err;
    jump_target_i = 32'h0000_01f0;
    redirect_to(PC_JUMP);
    collect(12);
    check_stream(32'h0000_01f0, 12);
    // Window covers exactly four words of this stream
    n_err = 0;
    for (int i = 0; i < 12 && base + i < got_err.size(); i++) begin
      if (got_err[base + i]) begin
        n_err++;
      end
    end
    check_val("if_id_err_o count", 32'(n_err), 32'd4);
  endtask

  initial begin : main
    @(posedge rst_n);
    test_boot();
    test_redirects();
    test_traps();
    test_backpressure();
    test_bus_error();
    repeat (4) @(posedge clk);
    $display("Result: %0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);

  // Free running clock, first rising edge at half a period
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset spans the first rising edges and drops on a falling edge
  initial begin
    rst_n = 1'b0;
    #(PERIOD_NS * RESET_CYCLES);
    rst_n = 1'b1;
  end

endmodule

/* if_stage_assert.sv */
`timescale 1ns/1ps

module if_stage_assert (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                pc_set_i,
  input  logic                id_ready_i,
  input  logic                instr_req_o,
  input  if_pkg::addr_t       instr_addr_o,
  input  logic                csr_mtvec_init_o,
  input  logic                if_valid_o,
  input  logic                if_id_valid_o,
  input  if_pkg::instr_word_t if_id_instr_o,
  input  if_pkg::addr_t       if_id_pc_o,
  input  logic                if_id_err_o,
  input  logic                if_busy_o
);

  // Word fetches only
  req_aligned_a: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o |-> (instr_addr_o[1:0] == 2'b00))
    else $error("fetch request with an unaligned address");

  // Mtvec init belongs to a boot redirect
  mtvec_init_a: assert property (@(posedge clk) disable iff (!rst_n)
    csr_mtvec_init_o |-> pc_set_i)
    else $error("csr_mtvec_init_o high without pc_set_i");

  // ID stall freezes the pipeline register
  if_id_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    (!id_ready_i && if_id_valid_o) |=> (if_id_valid_o && $stable(if_id_instr_o)
      && $stable(if_id_pc_o) && $stable(if_id_err_o)))
    else $error("IF/ID register changed while decode stalled");

  // Control outputs always resolved out of reset
  ctrl_known_a: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown({instr_req_o, if_valid_o, if_id_valid_o, csr_mtvec_init_o, if_busy_o}))
    else $error("unknown value on a control output");

endmodule

bind if_stage if_stage_assert if_stage_assert_inst (
  .clk              (clk),
  .rst_n            (rst_n),
  .pc_set_i         (pc_set_i),
  .id_ready_i       (id_ready_i),
  .instr_req_o      (instr_req_o),
  .instr_addr_o     (instr_addr_o),
  .csr_mtvec_init_o (csr_mtvec_init_o),
  .if_valid_o       (if_valid_o),
  .if_id_valid_o    (if_id_valid_o),
  .if_id_instr_o    (if_id_instr_o),
  .if_id_pc_o       (if_id_pc_o),
  .if_id_err_o      (if_id_err_o),
  .if_busy_o        (if_busy_o)
);

/* if_stage.sv */
`timescale 1ns/1ps

module if_stage #(
  parameter int unsigned FETCH_DEPTH = if_pkg::FETCH_DEPTH_DEF
) (
  input  logic                            clk,
  input  logic                            rst_n,

  // Controller redirect
  input  logic                            pc_set_i,
  input  if_pkg::pc_mux_e                 pc_mux_i,
  input  if_pkg::addr_t                   boot_addr_i,
  input  if_pkg::addr_t                   jump_target_i,
  input  if_pkg::addr_t                   branch_target_i,
  input  if_pkg::addr_t                   mepc_i,
  input  logic [if_pkg::MTVEC_BASE_W-1:0] mtvec_base_i,
  input  logic [if_pkg::IRQ_ID_W-1:0]     irq_id_i,
  output logic                            csr_mtvec_init_o,

  // Instruction bus
  output logic                            instr_req_o,
  output if_pkg::addr_t                   instr_addr_o,
  input  logic                            instr_rvalid_i,
  input  if_pkg::instr_word_t             instr_rdata_i,
  input  logic                            instr_err_i,

  // Stage control and IF/ID outputs
  input  logic                            halt_if_i,
  input  logic                            id_ready_i,
  output logic                            if_valid_o,
  output logic                            if_id_valid_o,
  output if_pkg::instr_word_t             if_id_instr_o,
  output if_pkg::addr_t                   if_id_pc_o,
  output logic                            if_id_err_o,

  // Status
  output logic                            if_busy_o,
  output if_pkg::addr_t                   pc_if_o
);

  import if_pkg::*;

  localparam int unsigned CNT_W = $clog2(FETCH_DEPTH + 1);

  // Redirect
  logic             redirect;
  addr_t            branch_addr;

  // Prefetcher to FIFO
  logic             push;
  instr_word_t      push_word;
  addr_t            push_pc;
  logic             push_err;
  logic [CNT_W-1:0] fifo_level;

  // FIFO to IF/ID register
  logic             fifo_valid;
  instr_word_t      fifo_word;
  logic             fifo_err;
  logic             pop;

  // The FIFO head during a redirect is old path, keep it out of ID
  logic             if_halt;

  assign if_halt = halt_if_i | redirect;

  ////////////////////////////////////////
  // Next PC select
  ////////////////////////////////////////

  if_pc_mux pc_mux_inst (
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .mtvec_base_i     (mtvec_base_i),
    .irq_id_i         (irq_id_i),
    .redirect_o       (redirect),
    .branch_addr_o    (branch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  ////////////////////////////////////////
  // Fetch and buffering
  ////////////////////////////////////////

  if_prefetcher #(
    .FETCH_DEPTH (FETCH_DEPTH)
  ) prefetcher_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .redirect_i     (redirect),
    .branch_addr_i  (branch_addr),
    .fifo_level_i   (fifo_level),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .push_o         (push),
    .push_word_o    (push_word),
    .push_pc_o      (push_pc),
    .push_err_o     (push_err),
    .busy_o         (if_busy_o)
  );

  // Flushed on every redirect
  if_fetch_fifo #(
    .FETCH_DEPTH (FETCH_DEPTH)
  ) fetch_fifo_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (redirect),
    .push_i      (push),
    .push_word_i (push_word),
    .push_pc_i   (push_pc),
    .push_err_i  (push_err),
    .pop_i       (pop),
    .valid_o     (fifo_valid),
    .word_o      (fifo_word),
    .pc_o        (pc_if_o),
    .err_o       (fifo_err),
    .level_o     (fifo_level)
  );

  ////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////

  if_id_register if_id_register_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .fifo_valid_i  (fifo_valid),
    .word_i        (fifo_word),
    .pc_i          (pc_if_o),
    .err_i         (fifo_err),
    .halt_if_i     (if_halt),
    .id_ready_i    (id_ready_i),
    .if_valid_o    (if_valid_o),
    .pop_o         (pop),
    .if_id_valid_o (if_id_valid_o),
    .if_id_instr_o (if_id_instr_o),
    .if_id_pc_o    (if_id_pc_o),
    .if_id_err_o   (if_id_err_o)
  );

endmodule

/* if_id_register.sv */
`timescale 1ns/1ps

module if_id_register (
  input  logic                clk,
  input  logic                rst_n,

  // Head of the fetch FIFO
  input  logic                fifo_valid_i,
  input  if_pkg::instr_word_t word_i,
  input  if_pkg::addr_t       pc_i,
  input  logic                err_i,

  // Stage control
  input  logic                halt_if_i,
  input  logic                id_ready_i,

  // Handshake toward ID and back to the FIFO
  output logic                if_valid_o,
  output logic                pop_o,

  // IF/ID pipeline register
  output logic                if_id_valid_o,
  output if_pkg::instr_word_t if_id_instr_o,
  output if_pkg::addr_t       if_id_pc_o,
  output logic                if_id_err_o
);

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////

  // IF offers an instruction unless halted
  assign if_valid_o = fifo_valid_i & ~halt_if_i;

  // Capture consumes the FIFO head
  assign pop_o = if_valid_o & id_ready_i;

  ////////////////////////////////////////
  // Pipeline register
  ////////////////////////////////////////

  // Valid and abort flag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_id_valid_o <= 1'b0;
      if_id_err_o   <= 1'b0;
    end else if (pop_o) begin
      if_id_valid_o <= 1'b1;
      // Bus error turns into an abort in decode
      if_id_err_o   <= err_i;
    end else if (id_ready_i) begin
      // ID took the old one and nothing new is offered
      if_id_valid_o <= 1'b0;
    end
  end

  // Instruction and PC, frozen while ID stalls
  always_ff @(posedge clk) begin
    if (pop_o) begin
      if_id_instr_o <= word_i;
      if_id_pc_o    <= pc_i;
    end
  end

endmodule

/* if_fetch_fifo.sv */
`timescale 1ns/1ps

module if_fetch_fifo #(
  parameter int unsigned FETCH_DEPTH = if_pkg::FETCH_DEPTH_DEF
) (
  input  logic                             clk,
  input  logic                             rst_n,

  // Drop all buffered words
  input  logic                             flush_i,

  // Write side from the prefetcher
  input  logic                             push_i,
  input  if_pkg::instr_word_t              push_word_i,
  input  if_pkg::addr_t                    push_pc_i,
  input  logic                             push_err_i,

  // Read side toward the IF/ID register
  input  logic                             pop_i,
  output logic                             valid_o,
  output if_pkg::instr_word_t              word_o,
  output if_pkg::addr_t                    pc_o,
  output logic                             err_o,
  output logic [$clog2(FETCH_DEPTH+1)-1:0] level_o
);

  import if_pkg::*;

  localparam int unsigned CNT_W = $clog2(FETCH_DEPTH + 1);
  localparam int unsigned PTR_W = $clog2(FETCH_DEPTH);

  // Entry storage
  instr_word_t          word_q [FETCH_DEPTH];
  addr_t                pc_q   [FETCH_DEPTH];
  logic [FETCH_DEPTH-1:0] err_q;

  // Circular buffer control
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     wr_idx;
  logic [CNT_W-1:0]     count_q;
  logic                 do_pop;

  // A push during flush lands in the first slot of the emptied buffer
  assign wr_idx = flush_i ? '0 : wr_ptr_q;

  // Pop only real entries, flush wins
  assign do_pop = pop_i & valid_o & ~flush_i;

  always_ff @(posedge clk) begin
    if (push_i) begin
      word_q[wr_idx] <= push_word_i;
      pc_q[wr_idx]   <= push_pc_i;
      err_q[wr_idx]  <= push_err_i;
    end
  end

  ////////////////////////////////////////
  // Pointers and count
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= PTR_W'(push_i);
      count_q  <= CNT_W'(push_i);
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FETCH_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FETCH_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push_i) - CNT_W'(do_pop);
    end
  end

  // Head of the buffer
  assign valid_o = (count_q != '0);
  assign word_o  = word_q[rd_ptr_q];
  assign pc_o    = pc_q[rd_ptr_q];
  assign err_o   = err_q[rd_ptr_q];
  assign level_o = count_q;

endmodule

/* if_prefetcher.sv */
`timescale 1ns/1ps

module if_prefetcher #(
  parameter int unsigned FETCH_DEPTH = if_pkg::FETCH_DEPTH_DEF
) (
  input  logic                             clk,
  input  logic                             rst_n,

  // Redirect from the PC mux
  input  logic                             redirect_i,
  input  if_pkg::addr_t                    branch_addr_i,

  // Current FIFO occupancy
  input  logic [$clog2(FETCH_DEPTH+1)-1:0] fifo_level_i,

  // Instruction bus, request side
  output logic                             instr_req_o,
  output if_pkg::addr_t                    instr_addr_o,

  // Instruction bus, response side
  input  logic                             instr_rvalid_i,
  input  if_pkg::instr_word_t              instr_rdata_i,
  input  logic                             instr_err_i,

  // Push into the fetch FIFO
  output logic                             push_o,
  output if_pkg::instr_word_t              push_word_o,
  output if_pkg::addr_t                    push_pc_o,
  output logic                             push_err_o,

  output logic                             busy_o
);

  import if_pkg::*;

  localparam int unsigned CNT_W = $clog2(FETCH_DEPTH + 1);
  localparam int unsigned PTR_W = $clog2(FETCH_DEPTH);
  localparam logic [CNT_W:0] LIMIT = (CNT_W + 1)'(FETCH_DEPTH);

  // Fetch address and run state
  addr_t            fetch_addr_q;
  logic             started_q;

  // Fetches in flight, and how many of them belong to an old path
  logic [CNT_W-1:0] outstanding_q;
  logic [CNT_W-1:0] stale_q;

  // Slots taken by in-flight fetches plus buffered words
  logic [CNT_W:0]   in_use;
  logic             drop_resp;

  // PCs of requests in flight, oldest at the read pointer
  addr_t            pc_queue_q [FETCH_DEPTH];
  logic [PTR_W-1:0] q_wr_ptr_q;
  logic [PTR_W-1:0] q_rd_ptr_q;

  ////////////////////////////////////////
  // Request side
  ////////////////////////////////////////

  assign in_use = {1'b0, outstanding_q} + {1'b0, fifo_level_i};

  // Idle until the first redirect
  // No request in the redirect cycle itself, the address is reloaded then
  assign instr_req_o  = started_q & ~redirect_i & (in_use < LIMIT);
  assign instr_addr_o = fetch_addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_addr_q <= '0;
      started_q    <= 1'b0;
    end else if (redirect_i) begin
      fetch_addr_q <= branch_addr_i;
      started_q    <= 1'b1;
    end else if (instr_req_o) begin
      // Sequential word fetch
      fetch_addr_q <= fetch_addr_q + 32'd4;
    end
  end

  ////////////////////////////////////////
  // Outstanding and stale tracking
  ////////////////////////////////////////

  // A response in the redirect cycle is already old path
  assign drop_resp = redirect_i | (stale_q != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= '0;
      stale_q       <= '0;
    end else begin
      outstanding_q <= outstanding_q + CNT_W'(instr_req_o) - CNT_W'(instr_rvalid_i);
      if (redirect_i) begin
        // Everything still in flight after this cycle is old path
        stale_q <= outstanding_q - CNT_W'(instr_rvalid_i);
      end else if (instr_rvalid_i && (stale_q != '0)) begin
        stale_q <= stale_q - 1'b1;
      end
    end
  end

  assign busy_o = (outstanding_q != '0);

  // PC queue entries
  always_ff @(posedge clk) begin
    if (instr_req_o) begin
      pc_queue_q[q_wr_ptr_q] <= fetch_addr_q;
    end
  end

  // Queue pointers keep running across redirects, stale entries pop too
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q_wr_ptr_q <= '0;
      q_rd_ptr_q <= '0;
    end else begin
      if (instr_req_o) begin
        q_wr_ptr_q <= (q_wr_ptr_q == PTR_W'(FETCH_DEPTH - 1)) ? '0 : q_wr_ptr_q + 1'b1;
      end
      if (instr_rvalid_i) begin
        q_rd_ptr_q <= (q_rd_ptr_q == PTR_W'(FETCH_DEPTH - 1)) ? '0 : q_rd_ptr_q + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Response side
  ////////////////////////////////////////

  // In-order bus, so the oldest queued PC belongs to this response
  assign push_o      = instr_rvalid_i & ~drop_resp;
  assign push_word_o = instr_rdata_i;
  assign push_pc_o   = pc_queue_q[q_rd_ptr_q];
  assign push_err_o  = instr_err_i;

endmodule

/* if_pc_mux.sv */
`timescale 1ns/1ps

module if_pc_mux (
  // Redirect request from the controller
  input  logic                           pc_set_i,
  input  if_pkg::pc_mux_e                pc_mux_i,

  // Candidate targets
  input  if_pkg::addr_t                  boot_addr_i,
  input  if_pkg::addr_t                  jump_target_i,
  input  if_pkg::addr_t                  branch_target_i,
  input  if_pkg::addr_t                  mepc_i,
  input  logic [if_pkg::MTVEC_BASE_W-1:0] mtvec_base_i,
  input  logic [if_pkg::IRQ_ID_W-1:0]    irq_id_i,

  // Toward the prefetcher and the CSR file
  output logic                           redirect_o,
  output if_pkg::addr_t                  branch_addr_o,
  output logic                           csr_mtvec_init_o
);

  import if_pkg::*;

  // Target before word alignment
  addr_t target_raw;

  // Target select by opcode
  always_comb begin
    case (pc_mux_i)
      PC_BOOT:     target_raw = boot_addr_i;
      PC_JUMP:     target_raw = jump_target_i;
      PC_BRANCH:   target_raw = branch_target_i;
      // Return from exception restores the saved PC
      PC_MRET:     target_raw = mepc_i;
      // All exceptions share the vector base
      PC_TRAP_EXC: target_raw = {mtvec_base_i, 7'b000_0000};
      // Interrupts are vectored by their ID, one word each
      PC_TRAP_IRQ: target_raw = {mtvec_base_i, irq_id_i, 2'b00};
      // Unused encodings fall back to boot
      default:     target_raw = boot_addr_i;
    endcase
  end

  // Only word fetches exist, so the two low bits are always cleared
  assign branch_addr_o = {target_raw[31:2], 2'b00};

  // Every pc_set is a redirect of the fetch stream
  assign redirect_o = pc_set_i;

  // Boot redirect tells the CSR file to load mtvec
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

/* if_pkg.sv */
package if_pkg;

  ////////////////////////////////////////
  // Basic widths and word types
  ////////////////////////////////////////

  // Byte address on the instruction side
  typedef logic [31:0] addr_t;

  // Raw 32-bit instruction word from memory
  typedef logic [31:0] instr_word_t;

  // Trap vector base, upper bits of a 128-byte aligned address
  localparam int unsigned MTVEC_BASE_W = 25;

  // Interrupt identifier used for vectored traps
  localparam int unsigned IRQ_ID_W = 5;

  ////////////////////////////////////////
  // Redirect sources
  ////////////////////////////////////////

  // Next-PC select driven by the controller
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5
  } pc_mux_e;

  ////////////////////////////////////////
  // Fetch buffering
  ////////////////////////////////////////

  // Default number of fetch FIFO entries
  // Also bounds the number of fetches in flight
  localparam int unsigned FETCH_DEPTH_DEF = 3;

endpackage
